// File: include/axi_rd_defs.svh
/*
 * AXI read encodings shared by the read master
 * Burst types, response codes and transfer size codes
 */
`ifndef AXI_RD_DEFS_SVH
`define AXI_RD_DEFS_SVH

// Burst types
localparam logic [1:0] BURST_FIXED = 2'b00;
localparam logic [1:0] BURST_INCR  = 2'b01;
localparam logic [1:0] BURST_WRAP  = 2'b10;

// Responses, ordered by severity
localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_EXOKAY = 2'b01;
localparam logic [1:0] RESP_SLVERR = 2'b10;
localparam logic [1:0] RESP_DECERR = 2'b11;

// Bytes per beat
localparam logic [2:0] SIZE_4B     = 3'b010;

`endif

// File: verilog/axi_rd_pkg.sv
/*
 * AXI read master package
 * Widths, table depths, request pattern and channel structs
 */
`default_nettype none

package axi_rd_pkg;

    `include "axi_rd_defs.svh"

    // ------------------------------------------------------------
    // Channel widths
    // ------------------------------------------------------------
    localparam int AXI_ID_W    = 4;
    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_DATA_W  = 32;
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    // ------------------------------------------------------------
    // Table depths and counters
    // ------------------------------------------------------------
    localparam int OST_DEPTH     = 4;
    localparam int OST_PTR_W     = 2;
    localparam int MAX_BURST_LEN = 8;
    localparam int BEAT_CNT_W    = 3;
    localparam int REQ_CNT_W     = 5;
    // Requests issued before done
    localparam int REQ_TOTAL     = 31;
    localparam int PATTERN_NUM   = 8;
    localparam int PATTERN_IDX_W = 3;

    // Every request is 4 beats of 4 bytes
    localparam logic [AXI_LEN_W-1:0]  REQ_LEN  = 8'd3;
    localparam logic [AXI_SIZE_W-1:0] REQ_SIZE = SIZE_4B;

    // Pattern entry 0 is listed first
    localparam logic [0:PATTERN_NUM-1][AXI_ADDR_W-1:0] PATTERN_ADDR = {
        32'h00, 32'h10, 32'h20, 32'h30, 32'h34, 32'h38, 32'h40, 32'h70
    };
    localparam logic [0:PATTERN_NUM-1][AXI_BURST_W-1:0] PATTERN_BURST = {
        BURST_INCR, BURST_INCR, BURST_INCR, BURST_FIXED,
        BURST_WRAP, BURST_WRAP, BURST_FIXED, BURST_INCR
    };

    typedef logic [OST_PTR_W-1:0] slot_ptr_t;
    typedef logic [OST_DEPTH-1:0] slot_vec_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]    id;
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_LEN_W-1:0]   len;
        logic [AXI_SIZE_W-1:0]  size;
        logic [AXI_BURST_W-1:0] burst;
    } ar_chan_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_RESP_W-1:0] resp;
        logic                  last;
    } r_chan_t;

    // Retired burst, beat 0 in the low word of data
    typedef struct packed {
        logic [AXI_ID_W-1:0]                      id;
        logic [AXI_RESP_W-1:0]                    resp;
        logic                                     err;
        logic [BEAT_CNT_W-1:0]                    beat_cnt;
        logic [MAX_BURST_LEN-1:0][AXI_DATA_W-1:0] data;
    } rd_result_t;

endpackage

`default_nettype wire

// File: verilog/rr_slot_arb.sv
/*
 * Round-robin slot picker
 * Points at the next requesting slot after the last one taken
 */
`default_nettype none

module rr_slot_arb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_rd_pkg::slot_vec_t req_vec,
    input  logic                  take,
    output axi_rd_pkg::slot_ptr_t ptr
);

    import axi_rd_pkg::*;

    // Slot granted on the last take
    slot_ptr_t last_q;

    // ------------------------------------------------------------
    // Search order starts one above the last grant
    // ------------------------------------------------------------
    always_comb begin
        // Idle pointer parks on the last grant
        ptr = last_q;
        // Walk downward so the nearest slot wins
        for (int k = OST_DEPTH; k >= 1; k--) begin
            if (req_vec[slot_ptr_t'(last_q + k)]) begin
                ptr = slot_ptr_t'(last_q + k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // First search begins at slot 0
            last_q <= slot_ptr_t'(OST_DEPTH - 1);
        end else if (take) begin
            last_q <= ptr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ost_status_table.sv
/*
 * Outstanding read status table
 * Per-slot flags and the allocate, issue and clear slot choice
 */
`default_nettype none

module ost_status_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  done,
    input  logic                  ar_fire,
    input  logic                  last_en,
    input  axi_rd_pkg::slot_ptr_t last_ptr,
    output logic                  alloc_en,
    output axi_rd_pkg::slot_ptr_t alloc_ptr,
    output axi_rd_pkg::slot_ptr_t issue_ptr,
    output logic                  ar_valid,
    output axi_rd_pkg::slot_vec_t pending_vec,
    output logic                  clr_en,
    output axi_rd_pkg::slot_ptr_t clr_ptr
);

    import axi_rd_pkg::*;

    // Slot in use, AR not yet sent, last beat not yet seen, ready to retire
    slot_vec_t valid_q;
    slot_vec_t req_q;
    slot_vec_t comp_q;
    slot_vec_t clr_q;

    // Stalled AR slot, locked until accepted
    logic      hold_q;
    slot_vec_t hold_vec_q;

    slot_vec_t free_vec;
    slot_vec_t issue_vec;

    // ------------------------------------------------------------
    // Slot choice
    // ------------------------------------------------------------
    assign free_vec = ~valid_q;
    assign alloc_en = enable & ~done & (|free_vec);

    // Newly allocated slots must not jump ahead of a stalled AR
    assign issue_vec = hold_q ? hold_vec_q : req_q;
    assign ar_valid  = |issue_vec;

    assign clr_en      = |clr_q;
    assign pending_vec = comp_q & ~req_q;

    rr_slot_arb u_alloc_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vec (free_vec),
        .take    (alloc_en),
        .ptr     (alloc_ptr)
    );

    rr_slot_arb u_issue_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vec (issue_vec),
        .take    (ar_fire),
        .ptr     (issue_ptr)
    );

    rr_slot_arb u_clr_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vec (clr_q),
        .take    (clr_en),
        .ptr     (clr_ptr)
    );

    // ------------------------------------------------------------
    // AR stall lock
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q     <= 1'b0;
            hold_vec_q <= '0;
        end else begin
            hold_q     <= ar_valid & ~ar_fire;
            hold_vec_q <= slot_vec_t'(1) << issue_ptr;
        end
    end

    // ------------------------------------------------------------
    // Per-slot flags
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            req_q   <= '0;
            comp_q  <= '0;
            clr_q   <= '0;
        end else begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                // Allocation arms all three flags together
                if (alloc_en && alloc_ptr == slot_ptr_t'(i)) begin
                    valid_q[i] <= 1'b1;
                    req_q[i]   <= 1'b1;
                    comp_q[i]  <= 1'b1;
                end else begin
                    if (clr_en && clr_ptr == slot_ptr_t'(i)) begin
                        valid_q[i] <= 1'b0;
                    end
                    if (ar_fire && issue_ptr == slot_ptr_t'(i)) begin
                        req_q[i] <= 1'b0;
                    end
                    if (last_en && last_ptr == slot_ptr_t'(i)) begin
                        comp_q[i] <= 1'b0;
                    end
                end
                // Retire candidate, dropped on the cycle it is taken
                clr_q[i] <= valid_q[i] & ~req_q[i] & ~comp_q[i]
                          & ~(clr_en && clr_ptr == slot_ptr_t'(i));
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ar_payload_table.sv
/*
 * AR payload table
 * Stores each slot's request from the pattern and counts requests
 */
`default_nettype none

module ar_payload_table (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            alloc_en,
    input  axi_rd_pkg::slot_ptr_t           alloc_ptr,
    input  axi_rd_pkg::slot_ptr_t           issue_ptr,
    output logic [axi_rd_pkg::AXI_ID_W-1:0] alloc_id,
    output axi_rd_pkg::ar_chan_t            ar,
    output logic                            done
);

    import axi_rd_pkg::*;

    // Requests allocated so far
    logic [REQ_CNT_W-1:0]     req_cnt_q;
    logic [PATTERN_IDX_W-1:0] pat_idx;

    // Request being allocated this cycle
    ar_chan_t alloc_ar;

    // One AR per slot
    ar_chan_t slot_q [OST_DEPTH];

    // ------------------------------------------------------------
    // New request from the pattern
    // ------------------------------------------------------------
    assign pat_idx = req_cnt_q[PATTERN_IDX_W-1:0];

    always_comb begin
        // ID wraps every 16 requests
        alloc_ar.id    = req_cnt_q[AXI_ID_W-1:0];
        alloc_ar.addr  = PATTERN_ADDR[pat_idx];
        alloc_ar.burst = PATTERN_BURST[pat_idx];
        // Shape is the same for all requests
        alloc_ar.len   = REQ_LEN;
        alloc_ar.size  = REQ_SIZE;
    end

    // Result table keeps the same id for R matching
    assign alloc_id = alloc_ar.id;

    // ------------------------------------------------------------
    // Request counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt_q <= '0;
        end else if (alloc_en) begin
            req_cnt_q <= req_cnt_q + 1'b1;
        end
    end

    // Holds at the total since allocation stops here
    assign done = (req_cnt_q == REQ_CNT_W'(REQ_TOTAL));

    // ------------------------------------------------------------
    // Slot storage
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            slot_q[alloc_ptr] <= alloc_ar;
        end
    end

    // Issue slot is held steady through an AR stall
    assign ar = slot_q[issue_ptr];

endmodule

`default_nettype wire

// File: verilog/r_result_table.sv
/*
 * Read result table
 * Matches R beats to pending slots by id and collects each burst
 */
`default_nettype none

module r_result_table (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            alloc_en,
    input  axi_rd_pkg::slot_ptr_t           alloc_ptr,
    input  logic [axi_rd_pkg::AXI_ID_W-1:0] alloc_id,
    input  logic                            r_valid,
    input  axi_rd_pkg::r_chan_t             r,
    input  axi_rd_pkg::slot_vec_t           pending_vec,
    input  logic                            clr_en,
    input  axi_rd_pkg::slot_ptr_t           clr_ptr,
    output logic                            last_en,
    output axi_rd_pkg::slot_ptr_t           last_ptr,
    output logic                            rd_result_valid,
    output axi_rd_pkg::rd_result_t          rd_result
);

    import axi_rd_pkg::*;

    // Per-slot burst state
    logic [AXI_ID_W-1:0]                      id_q   [OST_DEPTH];
    logic [BEAT_CNT_W-1:0]                    cnt_q  [OST_DEPTH];
    logic [AXI_RESP_W-1:0]                    resp_q [OST_DEPTH];
    logic [MAX_BURST_LEN-1:0][AXI_DATA_W-1:0] data_q [OST_DEPTH];

    // Beat owner
    slot_vec_t hit_vec;
    slot_ptr_t hit_ptr;
    logic      hit;

    // ------------------------------------------------------------
    // ID match against issued slots
    // ------------------------------------------------------------
    always_comb begin
        hit_ptr = '0;
        for (int i = 0; i < OST_DEPTH; i++) begin
            hit_vec[i] = r_valid & pending_vec[i] & (id_q[i] == r.id);
        end
        // Ids in flight are distinct so one bit at most is set
        for (int i = OST_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_ptr = slot_ptr_t'(i);
            end
        end
    end

    // Unknown ids fall through here
    assign hit      = |hit_vec;
    assign last_en  = hit & r.last;
    assign last_ptr = hit_ptr;

    // ------------------------------------------------------------
    // Beat counters
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                if (alloc_en && alloc_ptr == slot_ptr_t'(i)) begin
                    cnt_q[i] <= '0;
                end else if (hit_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Id, data beats and worst response
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < OST_DEPTH; i++) begin
            if (alloc_en && alloc_ptr == slot_ptr_t'(i)) begin
                id_q[i]   <= alloc_id;
                data_q[i] <= '0;
                resp_q[i] <= RESP_OKAY;
            end else if (hit_vec[i]) begin
                // Beats land in arrival order
                data_q[i][cnt_q[i]] <= r.data;
                // Higher code is more severe
                if (r.resp > resp_q[i]) begin
                    resp_q[i] <= r.resp;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Retire, on the cycle the slot is cleared
    // ------------------------------------------------------------
    assign rd_result_valid = clr_en;

    always_comb begin
        rd_result.id       = id_q[clr_ptr];
        rd_result.resp     = resp_q[clr_ptr];
        rd_result.err      = (resp_q[clr_ptr] == RESP_SLVERR)
                           | (resp_q[clr_ptr] == RESP_DECERR);
        rd_result.beat_cnt = cnt_q[clr_ptr];
        rd_result.data     = data_q[clr_ptr];
    end

endmodule

`default_nettype wire

// File: verilog/axi_rd_master.sv
/*
 * AXI4 read master traffic generator
 * Keeps up to four reads in flight and retires each burst's data
 */
`default_nettype none

module axi_rd_master (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    output logic                   done,
    // AR channel
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output axi_rd_pkg::ar_chan_t   ar,
    // R channel
    input  logic                   r_valid,
    output logic                   r_ready,
    input  axi_rd_pkg::r_chan_t    r,
    // Retire
    output logic                   rd_result_valid,
    output axi_rd_pkg::rd_result_t rd_result
);

    import axi_rd_pkg::*;

    logic                ar_fire;
    logic                alloc_en;
    slot_ptr_t           alloc_ptr;
    logic [AXI_ID_W-1:0] alloc_id;
    slot_ptr_t           issue_ptr;
    slot_vec_t           pending_vec;
    logic                clr_en;
    slot_ptr_t           clr_ptr;
    logic                last_en;
    slot_ptr_t           last_ptr;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------
    assign ar_fire = ar_valid & ar_ready;
    // Every beat is taken as it arrives
    assign r_ready = 1'b1;

    ost_status_table u_ost_status_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .done        (done),
        .ar_fire     (ar_fire),
        .last_en     (last_en),
        .last_ptr    (last_ptr),
        .alloc_en    (alloc_en),
        .alloc_ptr   (alloc_ptr),
        .issue_ptr   (issue_ptr),
        .ar_valid    (ar_valid),
        .pending_vec (pending_vec),
        .clr_en      (clr_en),
        .clr_ptr     (clr_ptr)
    );

    ar_payload_table u_ar_payload_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc_en  (alloc_en),
        .alloc_ptr (alloc_ptr),
        .issue_ptr (issue_ptr),
        .alloc_id  (alloc_id),
        .ar        (ar),
        .done      (done)
    );

    r_result_table u_r_result_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_en        (alloc_en),
        .alloc_ptr       (alloc_ptr),
        .alloc_id        (alloc_id),
        .r_valid         (r_valid),
        .r               (r),
        .pending_vec     (pending_vec),
        .clr_en          (clr_en),
        .clr_ptr         (clr_ptr),
        .last_en         (last_en),
        .last_ptr        (last_ptr),
        .rd_result_valid (rd_result_valid),
        .rd_result       (rd_result)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 */
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // Period of 10 time units
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/axi_rd_master_tb.sv
/*
 * Testbench for the AXI4 read master
 * AXI slave model and retire checks driven from a pattern file
 */
`default_nettype none

module axi_rd_master_tb;

    import axi_rd_pkg::*;

    localparam int ROWS     = 31;
    localparam int COLS     = 10;
    localparam int MAX_WAIT = 2000;
    localparam int QUIET    = 20;

    // Pattern file columns
    localparam int C_STALL = 0;
    localparam int C_SEED  = 1;
    localparam int C_RESP  = 2;
    localparam int C_ID    = 6;
    localparam int C_ADDR  = 7;
    localparam int C_BURST = 8;
    localparam int C_WORST = 9;

    logic       clk;
    logic       rst_n;
    logic       enable;
    logic       done;
    logic       ar_valid;
    logic       ar_ready;
    ar_chan_t   ar;
    logic       r_valid;
    logic       r_ready;
    r_chan_t    r;
    logic       rd_result_valid;
    rd_result_t rd_result;

    logic [31:0] pat_mem [ROWS*COLS];

    int       value_errs;
    int       other_errs;
    int       ar_cnt;
    int       retire_cnt;
    int       stall_cnt;
    ar_chan_t held_ar;
    logic     held_valid;

    // Rows accepted on AR, and rows whose last beat went out
    int issued_q[$];
    int sent_q[$];

    // Burst on the R channel
    logic cur_busy;
    int   cur_row;
    int   beat_k;

    tb_clk_gen u_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_master u_axi_rd_master (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (enable),
        .done            (done),
        .ar_valid        (ar_valid),
        .ar_ready        (ar_ready),
        .ar              (ar),
        .r_valid         (r_valid),
        .r_ready         (r_ready),
        .r               (r),
        .rd_result_valid (rd_result_valid),
        .rd_result       (rd_result)
    );

    // ------------------------------------------------------------
    // Pattern lookup
    // ------------------------------------------------------------
    function automatic logic [31:0] pat(input int row, input int col);
        return pat_mem[row*COLS + col];
    endfunction

    function automatic logic [AXI_ID_W-1:0] row_id(input int row);
        logic [31:0] id_w;
        id_w = pat(row, C_ID);
        return id_w[AXI_ID_W-1:0];
    endfunction

    function automatic ar_chan_t expected_ar(input int row);
        ar_chan_t    e;
        logic [31:0] burst_w;
        burst_w = pat(row, C_BURST);
        e.id    = row_id(row);
        e.addr  = pat(row, C_ADDR);
        // 4 beats of 4 bytes
        e.len   = 8'd3;
        e.size  = SIZE_4B;
        e.burst = burst_w[AXI_BURST_W-1:0];
        return e;
    endfunction

    function automatic rd_result_t expected_result(input int row);
        rd_result_t  e;
        logic [31:0] worst_w;
        logic [31:0] resp_w;
        worst_w    = pat(row, C_WORST);
        e          = '0;
        e.id       = row_id(row);
        e.resp     = worst_w[AXI_RESP_W-1:0];
        e.beat_cnt = 3'd4;
        // Unused beats stay zero
        for (int k = 0; k < 4; k++) begin
            e.data[k] = pat(row, C_SEED) + 32'(k);
            // Any error beat marks the burst
            resp_w = pat(row, C_RESP + k);
            if (resp_w[AXI_RESP_W-1:0] == RESP_SLVERR
                || resp_w[AXI_RESP_W-1:0] == RESP_DECERR) begin
                e.err = 1'b1;
            end
        end
        return e;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_ar(input string name, input ar_chan_t got, input ar_chan_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_result(input string name, input rd_result_t got,
                                input rd_result_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // Retire must belong to a burst whose last beat was sent
    task automatic match_retire();
        int idx;
        idx = -1;
        foreach (sent_q[i]) begin
            if (idx < 0 && row_id(sent_q[i]) == rd_result.id) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Retire with id %h matches no completed burst", rd_result.id);
            other_errs++;
        end else begin
            check_result("rd_result", rd_result, expected_result(sent_q[idx]));
            sent_q.delete(idx);
        end
        retire_cnt++;
    endtask

    // ------------------------------------------------------------
    // Monitor, samples on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            // R is never back-pressured
            check_bit("r_ready", r_ready, 1'b1);
            if (held_valid && !ar_valid) begin
                $display("ar_valid dropped before the AR handshake");
                other_errs++;
                held_valid = 1'b0;
            end
            if (ar_valid) begin
                if (ar_cnt >= ROWS) begin
                    $display("AR presented after all %0d requests", ROWS);
                    other_errs++;
                end else begin
                    check_ar("ar", ar, expected_ar(ar_cnt));
                    // Payload frozen during a stall
                    if (held_valid) begin
                        check_ar("ar held", ar, held_ar);
                    end
                    if (ar_ready) begin
                        issued_q.push_back(ar_cnt);
                        ar_cnt++;
                        stall_cnt  = 0;
                        held_valid = 1'b0;
                    end else begin
                        stall_cnt++;
                        held_ar    = ar;
                        held_valid = 1'b1;
                    end
                end
            end
            if (rd_result_valid) begin
                match_retire();
            end
            if (ar_cnt - retire_cnt > OST_DEPTH) begin
                $display("More than %0d reads outstanding", OST_DEPTH);
                other_errs++;
            end
        end
    end

    // ------------------------------------------------------------
    // Slave model, drives on the rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        logic [31:0] resp_w;
        int          tmp;
        if (rst_n) begin
            // Hold ready low for the row's stall count
            if (ar_cnt < ROWS) begin
                ar_ready <= (stall_cnt >= int'(pat(ar_cnt, C_STALL)));
            end else begin
                ar_ready <= 1'b0;
            end
            if (!cur_busy && issued_q.size() > 0) begin
                // Random reorder of the two oldest bursts
                if (issued_q.size() >= 2 && row_id(issued_q[0]) != row_id(issued_q[1])
                    && $urandom_range(1, 0) == 1) begin
                    tmp         = issued_q[0];
                    issued_q[0] = issued_q[1];
                    issued_q[1] = tmp;
                end
                cur_row  = issued_q.pop_front();
                cur_busy = 1'b1;
                beat_k   = 0;
            end
            // Random gap on about one cycle in four
            if (cur_busy && $urandom_range(3, 0) != 0) begin
                resp_w  = pat(cur_row, C_RESP + beat_k);
                r_valid <= 1'b1;
                r.id    <= row_id(cur_row);
                r.data  <= pat(cur_row, C_SEED) + 32'(beat_k);
                r.resp  <= resp_w[AXI_RESP_W-1:0];
                r.last  <= (beat_k == 3);
                beat_k++;
                if (beat_k == 4) begin
                    sent_q.push_back(cur_row);
                    cur_busy = 1'b0;
                end
            end else begin
                r_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int waited;
        bit aborted;
        value_errs = 0;
        other_errs = 0;
        ar_cnt     = 0;
        retire_cnt = 0;
        stall_cnt  = 0;
        held_valid = 1'b0;
        held_ar    = '0;
        cur_busy   = 1'b0;
        cur_row    = 0;
        beat_k     = 0;
        aborted    = 1'b0;
        enable     = 1'b0;
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r          = '0;
        void'($urandom(55151));
        $readmemh("verification/rd_patterns.hex", pat_mem);

        waited = 0;
        while (!rst_n && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            $display("Timeout waiting for reset release");
            other_errs++;
            aborted = 1'b1;
        end

        if (!aborted) begin
            // Quiet outputs out of reset
            @(negedge clk);
            check_bit("ar_valid", ar_valid, 1'b0);
            check_bit("rd_result_valid", rd_result_valid, 1'b0);
            check_bit("done", done, 1'b0);
            @(posedge clk);
            enable <= 1'b1;
            waited = 0;
            while (retire_cnt < ROWS && waited < MAX_WAIT) begin
                @(posedge clk);
                waited++;
            end
            if (retire_cnt < ROWS) begin
                $display("Timeout with %0d of %0d retires seen", retire_cnt, ROWS);
                other_errs++;
                aborted = 1'b1;
            end
        end

        if (!aborted) begin
            // Window where no AR or retire may appear
            waited = 0;
            while (waited < QUIET) begin
                @(posedge clk);
                waited++;
            end
            @(negedge clk);
            if (ar_cnt != ROWS || retire_cnt != ROWS) begin
                $display("Saw %0d ARs and %0d retires, expected %0d of each",
                         ar_cnt, retire_cnt, ROWS);
                other_errs++;
            end
            check_bit("done", done, 1'b1);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/rd_patterns.hex
// One row per request in AR order, all values hex
// stall seed resp0 resp1 resp2 resp3 id addr burst worst
0 a5000000 0 0 0 0 0 00000000 1 0
2 a5010000 0 1 0 0 1 00000010 1 1
1 a5020000 0 0 2 0 2 00000020 1 2
0 a5030000 3 0 0 0 3 00000030 0 3
3 a5040000 0 0 0 0 4 00000034 2 0
0 a5050000 1 1 1 1 5 00000038 2 1
0 a5060000 0 2 1 0 6 00000040 0 2
1 a5070000 0 0 0 3 7 00000070 1 3
0 a5080000 0 0 0 0 8 00000000 1 0
4 a5090000 2 3 0 1 9 00000010 1 3
0 a50a0000 0 0 1 0 a 00000020 1 1
2 a50b0000 0 0 0 0 b 00000030 0 0
0 a50c0000 1 0 2 0 c 00000034 2 2
1 a50d0000 0 0 0 0 d 00000038 2 0
0 a50e0000 0 3 0 0 e 00000040 0 3
0 a50f0000 0 0 0 1 f 00000070 1 1
2 a5100000 0 0 0 0 0 00000000 1 0
0 a5110000 2 0 0 0 1 00000010 1 2
5 a5120000 0 0 0 0 2 00000020 1 0
0 a5130000 1 0 0 0 3 00000030 0 1
1 a5140000 0 0 3 2 4 00000034 2 3
0 a5150000 0 0 0 0 5 00000038 2 0
3 a5160000 0 1 0 0 6 00000040 0 1
0 a5170000 0 0 0 2 7 00000070 1 2
0 a5180000 0 0 0 0 8 00000000 1 0
1 a5190000 3 3 0 0 9 00000010 1 3
0 a51a0000 0 0 0 0 a 00000020 1 0
2 a51b0000 0 2 0 1 b 00000030 0 2
0 a51c0000 1 0 0 0 c 00000034 2 1
0 a51d0000 0 0 0 0 d 00000038 2 0
1 a51e0000 2 0 0 3 e 00000040 0 3

// File: build.f
+incdir+include
verilog/axi_rd_pkg.sv
verilog/rr_slot_arb.sv
verilog/ost_status_table.sv
verilog/ar_payload_table.sv
verilog/r_result_table.sv
verilog/axi_rd_master.sv
verification/tb_clk_gen.sv
verification/axi_rd_master_tb.sv

// File: Makefile
# Verilator simulation of the AXI read master
TOP = axi_rd_master_tb

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
